//--- hdl/scope_defines.svh
/*
  Shared sizes of the acquisition loop
  - ADC and DAC word widths
  - Samples per triggered packet
  - Decimation shift range and shift port width
*/
`ifndef SCOPE_DEFINES_SVH
`define SCOPE_DEFINES_SVH

// ADC word width, 2 LSBs unused on 14-bit parts
`define ADC_DW 16
// DAC code width
`define DAC_DW 14
// Raw samples per triggered packet
`define ACQ_LEN 64
// Largest decimation shift, groups of up to 16
`define DEC_SHIFT_MAX 4
// Shift port must hold 0..DEC_SHIFT_MAX
`define DEC_SHIFT_W $clog2(`DEC_SHIFT_MAX + 1)

`endif

//--- hdl/stream_pkg.sv
/*
  Data types carried on the sample streams
  - Raw ADC pin word
  - Signed internal sample
  - DAC pin code
*/
`include "scope_defines.svh"

package stream_pkg;

  // Raw pin word, offset binary with negative slope
  typedef logic [`ADC_DW-1:0] adc_raw_t;

  // Two's complement sample on every internal stream
  typedef logic signed [`ADC_DW-1:0] sample_t;

  // Negative slope offset binary code for the DAC pins
  typedef logic [`DAC_DW-1:0] dac_code_t;

endpackage: stream_pkg

//--- hdl/ctrl_pkg.sv
/*
  Control encodings of the acquisition loop
  - Decimation mode
  - Trigger edge select
  - Trigger FSM states
*/
package ctrl_pkg;

  // Keep first word of group or average the group
  typedef enum logic {
    DEC_SKIP = 1'b0,
    DEC_AVG  = 1'b1
  } dec_mode_e;

  // Crossing direction through the trigger level
  typedef enum logic {
    TRIG_RISE = 1'b0,
    TRIG_FALL = 1'b1
  } trig_edge_e;

  // Gate FSM
  typedef enum logic [1:0] {
    TRIG_IDLE    = 2'd0,
    TRIG_ARMED   = 2'd1,
    TRIG_ACQUIRE = 2'd2
  } trig_state_e;

endpackage: ctrl_pkg

//--- hdl/sample_stream_if.sv
/*
  Sample stream between pipeline stages
  - tdata/tvalid/tready/tlast handshake
  - Source and sink views, clock and reset shared
*/
`timescale 1ns/1ps

interface sample_stream_if (
  input logic adc_clk,
  input logic top_rst
);
  import stream_pkg::*;

  // Payload
  sample_t tdata;
  logic    tlast;
  // Handshake, transfer on edge with both high
  logic    tvalid;
  logic    tready;

  // Producer side
  modport source (
    input  adc_clk, top_rst, tready,
    output tdata, tvalid, tlast
  );

  // Consumer side
  modport sink (
    input  adc_clk, top_rst, tdata, tvalid, tlast,
    output tready
  );

endinterface: sample_stream_if

//--- hdl/adc_capture.sv
/*
  ADC capture stage
  - Pin register, one word per cycle
  - Offset binary to two's complement conversion
  - Sticky flag for samples lost to back-pressure
*/
`timescale 1ns/1ps
`include "scope_defines.svh"

module adc_capture (
  input  stream_pkg::adc_raw_t adc_dat_i,
  output logic                 overflow_o,
  sample_stream_if.source      str_o
);
  import stream_pkg::*;

  // Pin word register and stream valid
  adc_raw_t raw_q;
  logic     valid_q;

  //////////////////////////////
  // Input register
  //////////////////////////////

  // Overwritten every cycle, ready or not
  always_ff @(posedge str_o.adc_clk) begin
    raw_q <= adc_dat_i;
  end

  // Stream valid from first edge after reset
  always_ff @(posedge str_o.adc_clk, posedge str_o.top_rst) begin
    if (str_o.top_rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  // Negative slope, keep MSB and flip the rest
  assign str_o.tdata  = {raw_q[`ADC_DW-1], ~raw_q[`ADC_DW-2:0]};
  assign str_o.tvalid = valid_q;
  // Raw stream has no packets
  assign str_o.tlast  = 1'b0;

  //////////////////////////////
  // Overflow
  //////////////////////////////

  // Valid word not taken, lost on this edge
  always_ff @(posedge str_o.adc_clk, posedge str_o.top_rst) begin
    if (str_o.top_rst) begin
      overflow_o <= 1'b0;
    end else if (str_o.tvalid && !str_o.tready) begin
      overflow_o <= 1'b1;
    end
  end

endmodule: adc_capture

//--- hdl/trigger_gate.sv
/*
  Trigger gate
  - Arm / level crossing / acquire FSM
  - Passes ACQ_LEN words from the trigger word on, tlast on the final one
  - Discards the stream outside a packet
*/
`timescale 1ns/1ps
`include "scope_defines.svh"

module trigger_gate (
  input  logic                  arm_i,
  input  stream_pkg::sample_t   trig_level_i,
  input  ctrl_pkg::trig_edge_e  trig_edge_i,
  output logic                  acq_busy_o,
  sample_stream_if.sink         str_i,
  sample_stream_if.source       str_o
);
  import stream_pkg::*;
  import ctrl_pkg::*;

  localparam int unsigned CNT_W = $clog2(`ACQ_LEN);
  // Index of the word that carries tlast
  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`ACQ_LEN - 1);

  trig_state_e      state_q;
  logic [CNT_W-1:0] cnt_q;
  sample_t          prev_q;
  logic             hit;
  logic             pass;
  logic             in_hs;
  logic             out_hs;

  //////////////////////////////
  // Crossing detection
  //////////////////////////////

  // Previous accepted sample vs current one
  always_comb begin
    case (trig_edge_i)
      TRIG_RISE: hit = (prev_q < trig_level_i) && (str_i.tdata >= trig_level_i);
      default:   hit = (prev_q > trig_level_i) && (str_i.tdata <= trig_level_i);
    endcase
  end

  // Every accepted word becomes the new reference
  always_ff @(posedge str_i.adc_clk) begin
    if (in_hs) begin
      prev_q <= str_i.tdata;
    end
  end

  //////////////////////////////
  // Stream gating
  //////////////////////////////

  // Words inside a packet, trigger word included
  assign pass = (state_q == TRIG_ACQUIRE) || ((state_q == TRIG_ARMED) && hit);

  // Outside a packet everything is taken and dropped
  assign str_i.tready = pass ? str_o.tready : 1'b1;
  assign str_o.tvalid = str_i.tvalid && pass;
  assign str_o.tdata  = str_i.tdata;
  assign str_o.tlast  = (cnt_q == LAST_IDX);

  assign in_hs  = str_i.tvalid && str_i.tready;
  assign out_hs = str_o.tvalid && str_o.tready;

  //////////////////////////////
  // FSM and word counter
  //////////////////////////////

  always_ff @(posedge str_i.adc_clk, posedge str_i.top_rst) begin
    if (str_i.top_rst) begin
      state_q <= TRIG_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        // Arm pulse only counts here
        TRIG_IDLE: begin
          if (arm_i) begin
            state_q <= TRIG_ARMED;
          end
        end
        TRIG_ARMED, TRIG_ACQUIRE: begin
          if (out_hs) begin
            if (str_o.tlast) begin
              state_q <= TRIG_IDLE;
              cnt_q   <= '0;
            end else begin
              state_q <= TRIG_ACQUIRE;
              cnt_q   <= cnt_q + 1'b1;
            end
          end
        end
        default: state_q <= TRIG_IDLE;
      endcase
    end
  end

  assign acq_busy_o = (state_q != TRIG_IDLE);

endmodule: trigger_gate

//--- hdl/sample_decimator.sv
/*
  Decimator by 2**dec_shift_i
  - Skip mode keeps the first word of each group
  - Average mode shifts the group sum right
  - Groups restart at packet boundaries, tlast forwarded
*/
`timescale 1ns/1ps
`include "scope_defines.svh"

module sample_decimator (
  input  ctrl_pkg::dec_mode_e     dec_mode_i,
  input  logic [`DEC_SHIFT_W-1:0] dec_shift_i,
  sample_stream_if.sink           str_i,
  sample_stream_if.source         str_o
);
  import stream_pkg::*;
  import ctrl_pkg::*;

  // Sum of up to 2**DEC_SHIFT_MAX words needs that much headroom
  localparam int unsigned ACC_W = `ADC_DW + `DEC_SHIFT_MAX;

  logic [`DEC_SHIFT_MAX-1:0] grp_cnt_q;
  logic [`DEC_SHIFT_MAX-1:0] grp_last;
  logic signed [ACC_W-1:0]   acc_q;
  logic signed [ACC_W-1:0]   acc_next;
  logic signed [ACC_W-1:0]   acc_shr;
  sample_t                   first_q;
  sample_t                   first;
  sample_t                   out_dat_q;
  logic                      out_vld_q;
  logic                      out_lst_q;
  logic                      accept;
  logic                      grp_end;

  // Take input while output is free or leaving
  assign str_i.tready = !out_vld_q || str_o.tready;
  assign accept       = str_i.tvalid && str_i.tready;

  // Index of the final word of a full group
  assign grp_last = ~({`DEC_SHIFT_MAX{1'b1}} << dec_shift_i);
  // Short group at end of packet
  assign grp_end  = (grp_cnt_q == grp_last) || str_i.tlast;

  // Sum starts fresh at group index 0
  assign acc_next = (grp_cnt_q == '0 ? '0 : acc_q)
                  + {{`DEC_SHIFT_MAX{str_i.tdata[`ADC_DW-1]}}, str_i.tdata};
  assign acc_shr  = acc_next >>> dec_shift_i;
  assign first    = (grp_cnt_q == '0) ? str_i.tdata : first_q;

  //////////////////////////////
  // Group accumulation
  //////////////////////////////

  always_ff @(posedge str_i.adc_clk) begin
    if (accept) begin
      acc_q   <= acc_next;
      first_q <= first;
    end
  end

  always_ff @(posedge str_i.adc_clk, posedge str_i.top_rst) begin
    if (str_i.top_rst) begin
      grp_cnt_q <= '0;
    end else if (accept) begin
      grp_cnt_q <= grp_end ? '0 : grp_cnt_q + 1'b1;
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  // Result one edge after the last word of the group
  always_ff @(posedge str_i.adc_clk) begin
    if (accept && grp_end) begin
      out_dat_q <= (dec_mode_i == DEC_AVG) ? acc_shr[`ADC_DW-1:0] : first;
      out_lst_q <= str_i.tlast;
    end
  end

  always_ff @(posedge str_i.adc_clk, posedge str_i.top_rst) begin
    if (str_i.top_rst) begin
      out_vld_q <= 1'b0;
    end else if (accept && grp_end) begin
      out_vld_q <= 1'b1;
    end else if (str_o.tready) begin
      out_vld_q <= 1'b0;
    end
  end

  assign str_o.tdata  = out_dat_q;
  assign str_o.tvalid = out_vld_q;
  assign str_o.tlast  = out_lst_q;

endmodule: sample_decimator

//--- hdl/dac_format.sv
/*
  DAC output formatter
  - Signed sample to 14-bit negative slope code
  - Output register held until next write
  - Write strobe kept up until the DAC side takes it
*/
`timescale 1ns/1ps
`include "scope_defines.svh"

module dac_format (
  sample_stream_if.sink         str_i,
  input  logic                  dac_ready_i,
  output stream_pkg::dac_code_t dac_dat_o,
  output logic                  dac_wrt_o,
  output logic                  dac_last_o
);
  import stream_pkg::*;

  // Zero volts on a negative slope DAC
  localparam dac_code_t MID_SCALE = dac_code_t'((1 << (`DAC_DW - 1)) - 1);

  logic accept;

  // Register free or its code taken this cycle
  assign str_i.tready = !dac_wrt_o || dac_ready_i;
  assign accept       = str_i.tvalid && str_i.tready;

  // Top bits, sign kept and magnitude bits flipped
  always_ff @(posedge str_i.adc_clk, posedge str_i.top_rst) begin
    if (str_i.top_rst) begin
      dac_dat_o  <= MID_SCALE;
      dac_wrt_o  <= 1'b0;
      dac_last_o <= 1'b0;
    end else if (accept) begin
      dac_dat_o  <= {str_i.tdata[`ADC_DW-1], ~str_i.tdata[`ADC_DW-2:`ADC_DW-`DAC_DW]};
      dac_wrt_o  <= 1'b1;
      dac_last_o <= str_i.tlast;
    end else if (dac_ready_i) begin
      // Code stays on the pins, only strobe drops
      dac_wrt_o  <= 1'b0;
    end
  end

endmodule: dac_format

//--- hdl/scope_loop_top.sv
/*
  Acquisition and loopback top
  - Capture, trigger gate, decimator, DAC formatter
  - Stages joined by sample streams in the adc_clk domain
*/
`timescale 1ns/1ps
`include "scope_defines.svh"

module scope_loop_top (
  input  logic                    adc_clk,
  input  logic                    top_rst,
  // ADC pins
  input  stream_pkg::adc_raw_t    adc_dat_i,
  // Trigger control
  input  logic                    arm_i,
  input  stream_pkg::sample_t     trig_level_i,
  input  ctrl_pkg::trig_edge_e    trig_edge_i,
  // Decimation control
  input  ctrl_pkg::dec_mode_e     dec_mode_i,
  input  logic [`DEC_SHIFT_W-1:0] dec_shift_i,
  // DAC pins
  input  logic                    dac_ready_i,
  output stream_pkg::dac_code_t   dac_dat_o,
  output logic                    dac_wrt_o,
  output logic                    dac_last_o,
  // Status
  output logic                    acq_busy_o,
  output logic                    overflow_o
);

  //////////////////////////////
  // Streams
  //////////////////////////////

  sample_stream_if s_cap  (.adc_clk (adc_clk), .top_rst (top_rst));
  sample_stream_if s_gate (.adc_clk (adc_clk), .top_rst (top_rst));
  sample_stream_if s_dec  (.adc_clk (adc_clk), .top_rst (top_rst));

  //////////////////////////////
  // Pipeline stages
  //////////////////////////////

  adc_capture cap (
    .adc_dat_i  (adc_dat_i ),
    .overflow_o (overflow_o),
    .str_o      (s_cap     )
  );

  trigger_gate gate (
    .arm_i        (arm_i       ),
    .trig_level_i (trig_level_i),
    .trig_edge_i  (trig_edge_i ),
    .acq_busy_o   (acq_busy_o  ),
    .str_i        (s_cap       ),
    .str_o        (s_gate      )
  );

  sample_decimator dec (
    .dec_mode_i  (dec_mode_i ),
    .dec_shift_i (dec_shift_i),
    .str_i       (s_gate     ),
    .str_o       (s_dec      )
  );

  dac_format fmt (
    .str_i       (s_dec      ),
    .dac_ready_i (dac_ready_i),
    .dac_dat_o   (dac_dat_o  ),
    .dac_wrt_o   (dac_wrt_o  ),
    .dac_last_o  (dac_last_o )
  );

endmodule: scope_loop_top

//--- test/tb_scope_loop.sv
/*
  Testbench of the acquisition and loopback top
  - Clock, reset, falling-edge stimulus and DAC ready pattern
  - Reference model of capture, trigger, decimation and DAC code
  - Assertions on every DAC write, on reset state and on the overflow flag
  - Watchdog and per-test result lines
*/
`timescale 1ns/1ps
`include "scope_defines.svh"

module tb_scope_loop;
  import stream_pkg::*;
  import ctrl_pkg::*;

  typedef logic [`DEC_SHIFT_W-1:0] shift_t;

  localparam int CLK_PERIOD = 10;
  localparam int TRIG_LEVEL = 300;
  localparam int SEED       = 32'he9df_bb48;
  // Stimulus words per test
  localparam int N_NOARM    = 60;
  localparam int N_RAMP     = 100;
  localparam int N_RAND     = 90;
  localparam int N_FALL     = 120;
  localparam int STIM_TOTAL = N_NOARM + 2 * N_RAMP + 2 * N_RAND + N_FALL;
  localparam int WATCHDOG_NS = STIM_TOTAL * (1 << `DEC_SHIFT_MAX) * CLK_PERIOD * 4;

  logic       adc_clk;
  logic       top_rst;
  adc_raw_t   adc_dat_i;
  logic       arm_i;
  sample_t    trig_level_i;
  trig_edge_e trig_edge_i;
  dec_mode_e  dec_mode_i;
  shift_t     dec_shift_i;
  logic       dac_ready_i;
  dac_code_t  dac_dat_o;
  logic       dac_wrt_o;
  logic       dac_last_o;
  logic       acq_busy_o;
  logic       overflow_o;

  // Model state and bookkeeping
  adc_raw_t  raw_words[$];
  dac_code_t exp_code[$];
  bit        exp_last[$];
  dac_code_t exp_c;
  bit        exp_l;
  string     test_name;
  int        errors;
  int        writes;
  int        test_err0;
  int        tests_passed;
  int        tests_failed;
  int        ready_mode;
  bit        check_en;

  scope_loop_top uut (
    .adc_clk      (adc_clk     ),
    .top_rst      (top_rst     ),
    .adc_dat_i    (adc_dat_i   ),
    .arm_i        (arm_i       ),
    .trig_level_i (trig_level_i),
    .trig_edge_i  (trig_edge_i ),
    .dec_mode_i   (dec_mode_i  ),
    .dec_shift_i  (dec_shift_i ),
    .dac_ready_i  (dac_ready_i ),
    .dac_dat_o    (dac_dat_o   ),
    .dac_wrt_o    (dac_wrt_o   ),
    .dac_last_o   (dac_last_o  ),
    .acq_busy_o   (acq_busy_o  ),
    .overflow_o   (overflow_o  )
  );

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  //////////////////////////////
  // Model functions
  //////////////////////////////

  // Negative slope offset binary, raw 0 is full positive
  function automatic int to_sample(input adc_raw_t raw);
    return 32767 - int'(raw);
  endfunction

  // Mid-scale 0x1FFF at zero, code falls as the sample rises
  function automatic dac_code_t to_dac_code(input int s);
    return dac_code_t'(8191 - (s >>> 2));
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual) else begin
      errors++;
      $display("[ERROR] %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  // Words pushed as raw pin values
  task automatic load_ramp(input int n, input int start, input int step);
    for (int i = 0; i < n; i++) begin
      raw_words.push_back(adc_raw_t'(32767 - (start + step * i)));
    end
  endtask

  task automatic load_random(input int n);
    for (int i = 0; i < n; i++) begin
      raw_words.push_back(adc_raw_t'($urandom_range(0, 65535)));
    end
  endtask

  // Trigger search from the arm word, then decimation of the packet
  task automatic predict(input int arm_idx, input trig_edge_e edge_sel,
                         input dec_mode_e mode, input int shift);
    int t;
    int prev;
    int cur;
    int grp;
    int acc;
    int res;
    t = -1;
    for (int i = arm_idx; i < raw_words.size() && t < 0; i++) begin
      prev = to_sample(raw_words[i-1]);
      cur  = to_sample(raw_words[i]);
      if (edge_sel == TRIG_RISE && prev < TRIG_LEVEL && cur >= TRIG_LEVEL) begin
        t = i;
      end else if (edge_sel == TRIG_FALL && prev > TRIG_LEVEL && cur <= TRIG_LEVEL) begin
        t = i;
      end
    end
    if (t < 0 || t + `ACQ_LEN > raw_words.size()) begin
      errors++;
      $display("[ERROR] %s: stimulus holds no complete triggered packet", test_name);
    end else begin
      grp = 1 << shift;
      for (int k = 0; k < `ACQ_LEN / grp; k++) begin
        acc = 0;
        for (int j = 0; j < grp; j++) begin
          acc += to_sample(raw_words[t + k * grp + j]);
        end
        res = (mode == DEC_AVG) ? (acc >>> shift) : to_sample(raw_words[t + k * grp]);
        exp_code.push_back(to_dac_code(res));
        exp_last.push_back(k == `ACQ_LEN / grp - 1);
      end
    end
  endtask

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  task automatic apply_reset();
    @(negedge adc_clk);
    top_rst = 1'b1;
    repeat (5) @(negedge adc_clk);
    top_rst = 1'b0;
  endtask

  task automatic check_reset_outputs();
    check_value("dac_wrt_o", 0, 32'(dac_wrt_o));
    check_value("dac_last_o", 0, 32'(dac_last_o));
    check_value("acq_busy_o", 0, 32'(acq_busy_o));
    check_value("overflow_o", 0, 32'(overflow_o));
    check_value("dac_dat_o", 32'h1fff, 32'(dac_dat_o));
  endtask

  // Static configuration, set while the gate is idle
  task automatic configure(input trig_edge_e edge_sel, input dec_mode_e mode,
                           input int shift, input int rmode);
    @(negedge adc_clk);
    trig_edge_i = edge_sel;
    dec_mode_i  = mode;
    dec_shift_i = shift_t'(shift);
    // Ready pattern switches from the next falling edge on
    ready_mode <= rmode;
  endtask

  // One word per falling edge, arm pulse with word arm_idx
  task automatic drive_words(input int arm_idx);
    for (int i = 0; i < raw_words.size(); i++) begin
      @(negedge adc_clk);
      adc_dat_i = raw_words[i];
      arm_i     = (i == arm_idx);
    end
  endtask

  // Done once every expected code is taken
  task automatic wait_idle();
    while (exp_code.size() != 0) begin
      @(negedge adc_clk);
    end
    // Short drain catches stray writes
    repeat (8) @(negedge adc_clk);
  endtask

  task automatic run_test(input trig_edge_e edge_sel, input dec_mode_e mode,
                          input int shift, input int arm_idx, input int rmode);
    int wr0;
    int n_exp;
    configure(edge_sel, mode, shift, rmode);
    if (arm_idx >= 0) begin
      predict(arm_idx, edge_sel, mode, shift);
    end
    n_exp = exp_code.size();
    wr0   = writes;
    drive_words(arm_idx);
    wait_idle();
    check_value("write count", n_exp, writes - wr0);
    raw_words.delete();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    if (errors == test_err0) begin
      tests_passed++;
      $display("[PASS] %s", test_name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s with %0d errors", test_name, errors - test_err0);
    end
  endtask

  //////////////////////////////
  // DAC side and checkers
  //////////////////////////////

  // Random ready never low twice in a row, so capture loses nothing
  always @(negedge adc_clk) begin
    case (ready_mode)
      0:       dac_ready_i = 1'b1;
      1:       dac_ready_i = dac_ready_i ? 1'($urandom_range(0, 1)) : 1'b1;
      default: dac_ready_i = 1'b0;
    endcase
  end

  // Code taken on each edge with strobe and ready high
  always @(posedge adc_clk) begin
    if (!top_rst && dac_wrt_o && dac_ready_i) begin
      writes++;
      assert (!check_en || exp_code.size() != 0) else begin
        errors++;
        $display("[ERROR] %s: DAC write with no expected code", test_name);
      end
      if (check_en && exp_code.size() != 0) begin
        exp_c = exp_code.pop_front();
        exp_l = exp_last.pop_front();
        check_value("dac_dat_o", 32'(exp_c), 32'(dac_dat_o));
        check_value("dac_last_o", 32'(exp_l), 32'(dac_last_o));
      end
    end
  end

  reset_state_a: assert property (@(posedge adc_clk) top_rst |->
      (!dac_wrt_o && !dac_last_o && !acq_busy_o && !overflow_o && dac_dat_o == 14'h1fff))
    else begin
      errors++;
      $display("[ERROR] %s: outputs not at their reset values during reset", test_name);
    end

  overflow_sticky_a: assert property (@(posedge adc_clk) disable iff (top_rst)
      overflow_o |=> overflow_o)
    else begin
      errors++;
      $display("[ERROR] %s: overflow flag cleared without a reset", test_name);
    end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(SEED));
    adc_clk      = 1'b0;
    top_rst      = 1'b0;
    adc_dat_i    = '0;
    arm_i        = 1'b0;
    trig_level_i = sample_t'(TRIG_LEVEL);
    trig_edge_i  = TRIG_RISE;
    dec_mode_i   = DEC_SKIP;
    dec_shift_i  = '0;
    dac_ready_i  = 1'b1;
    ready_mode  <= 0;
    check_en     = 1'b1;
    errors       = 0;
    writes       = 0;
    tests_passed = 0;
    tests_failed = 0;

    start_test("reset_state");
    apply_reset();
    check_reset_outputs();
    load_ramp(N_NOARM, -2000, 100);
    run_test(TRIG_RISE, DEC_SKIP, 0, -1, 0);
    end_test();

    start_test("rise_no_decimation");
    load_ramp(N_RAMP, -2000, 100);
    run_test(TRIG_RISE, DEC_SKIP, 0, 5, 0);
    check_value("acq_busy_o", 0, 32'(acq_busy_o));
    end_test();

    start_test("average_shift2");
    load_ramp(5, -1000, 0);
    load_ramp(2, -500, 1000);
    load_random(N_RAND - 7);
    run_test(TRIG_RISE, DEC_AVG, 2, 3, 0);
    end_test();

    // Upward crossing first, packet starts on the way down
    start_test("fall_skip_shift4");
    load_ramp(5, -3000, 0);
    load_ramp(15, -2600, 400);
    load_ramp(N_FALL - 20, 2900, -100);
    run_test(TRIG_FALL, DEC_SKIP, 4, 2, 0);
    end_test();

    start_test("backpressure_shift3");
    load_ramp(5, -1000, 0);
    load_ramp(2, -500, 1000);
    load_random(N_RAND - 7);
    run_test(TRIG_RISE, DEC_AVG, 3, 3, 1);
    check_value("overflow_o", 0, 32'(overflow_o));
    end_test();

    // DAC stalled through a whole packet
    start_test("overflow");
    check_en = 1'b0;
    load_ramp(N_RAMP, -2000, 100);
    configure(TRIG_RISE, DEC_SKIP, 0, 2);
    drive_words(5);
    check_value("overflow_o", 1, 32'(overflow_o));
    ready_mode <= 0;
    // Stalled packet completes once the DAC takes codes again
    while (acq_busy_o) begin
      @(negedge adc_clk);
    end
    wait_idle();
    check_value("overflow_o", 1, 32'(overflow_o));
    apply_reset();
    check_reset_outputs();
    raw_words.delete();
    check_en = 1'b1;
    end_test();

    $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("[ERROR] watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule: tb_scope_loop

//--- src.f
+incdir+hdl
hdl/stream_pkg.sv
hdl/ctrl_pkg.sv
hdl/sample_stream_if.sv
hdl/adc_capture.sv
hdl/trigger_gate.sv
hdl/sample_decimator.sv
hdl/dac_format.sv
hdl/scope_loop_top.sv
test/tb_scope_loop.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the scope loop testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_scope_loop -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
  exit 0
fi
exit 1
